/* vlog.f */
+incdir+hdl
hdl/axi4l_pkg.sv
hdl/axi4l_intf.sv
hdl/bus_intf.sv
hdl/axi4l_to_bus_adapter.sv
hdl/bus_pipe.sv
hdl/bus_reg_block.sv
hdl/axi4l_reg_top.sv
tests/axi4l_reg_checker.sv
tests/axi4l_reg_tb.sv

/* Bender.yml */
package:
  name: axi4l_reg

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/axi4l_pkg.sv
      - hdl/axi4l_intf.sv
      - hdl/bus_intf.sv
      - hdl/axi4l_to_bus_adapter.sv
      - hdl/bus_pipe.sv
      - hdl/bus_reg_block.sv
      - hdl/axi4l_reg_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/axi4l_reg_checker.sv
      - tests/axi4l_reg_tb.sv

/* tests/axi4l_reg_tb.sv */
// Fixed-seed random run; relies on the bound checker instance u_checker inside u_dut
`default_nettype none

`include "axi4l_consts.svh"

module axi4l_reg_tb
    import axi4l_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int REG_COUNT       = `AXI4L_REG_COUNT;
    localparam int ADDR_LIMIT      = `AXI4L_REG_COUNT * `AXI4L_DATA_BYTE_WID;
    localparam logic [31:0] SEED   = 32'hd568;
    localparam int N_PAIR          = 64;
    localparam int N_BAD           = 16;
    localparam int N_MIX           = 200;
    localparam int N_TXN           = 2 * REG_COUNT + 2 * N_PAIR + N_BAD + N_MIX;
    localparam int WATCHDOG_CYCLES = 16 + N_TXN * 40;

    logic        clk;
    logic        arst_n;
    logic        awvalid;
    logic        awready;
    logic [7:0]  awaddr;
    logic [2:0]  awprot;
    logic        wvalid;
    logic        wready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bvalid;
    logic        bready;
    resp_t       bresp;
    logic        arvalid;
    logic        arready;
    logic [7:0]  araddr;
    logic [2:0]  arprot;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    resp_t       rresp;

    // Reference model and outstanding expectations per channel
    logic [31:0] model_regs [REG_COUNT];
    resp_t       exp_b_q [$];
    resp_t       exp_r_resp_q [$];
    logic [31:0] exp_r_data_q [$];

    logic [31:0] rng_state;
    logic [31:0] ready_state;
    string       test_name;
    int          resp_errs;
    int          data_errs;
    int          proto_errs;

    axi4l_reg_top u_dut (.*);

    bind axi4l_reg_top axi4l_reg_checker u_checker (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Upper bits only, the low LCG bits repeat quickly
    function automatic int rnd_below(input int n);
        rng_state = lcg_next(rng_state);
        return int'(rng_state[31:16]) % n;
    endfunction

    function automatic logic [31:0] rnd_word();
        logic [15:0] hi;
        hi = 16'(rnd_below(65536));
        return {hi, 16'(rnd_below(65536))};
    endfunction

    // Kind 0 valid, 1 unaligned, 2 out of range
    function automatic logic [7:0] make_addr(input int kind);
        int base;
        base = rnd_below(REG_COUNT) * 4;
        if (kind == 1) begin
            return 8'(base + 1 + rnd_below(3));
        end else if (kind == 2) begin
            return 8'(ADDR_LIMIT + rnd_below(256 - ADDR_LIMIT));
        end
        return 8'(base);
    endfunction

    function automatic logic addr_ok(input logic [7:0] addr);
        return (addr % 4 == 0) && (addr < ADDR_LIMIT);
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                                input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic check_resp(input string test, input resp_t exp, input resp_t act);
        if (act !== exp) begin
            resp_errs++;
            $display("ERR %s expected %s actual %s (%b)", test, exp.name(), act.name(), act);
        end
    endtask

    task automatic check_data(input string test, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            data_errs++;
            $display("ERR %s expected %08h actual %08h", test, exp, act);
        end
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic send_aw(input logic [7:0] addr, input logic [2:0] prot, input int gap);
        repeat (gap) tick();
        awvalid = 1'b1;
        awaddr  = addr;
        awprot  = prot;
        @(negedge clk);
        while (!awready) @(negedge clk);
        tick();
        awvalid = 1'b0;
    endtask

    task automatic send_w(input logic [31:0] data, input logic [3:0] strb, input int gap);
        repeat (gap) tick();
        wvalid = 1'b1;
        wdata  = data;
        wstrb  = strb;
        @(negedge clk);
        while (!wready) @(negedge clk);
        tick();
        wvalid = 1'b0;
    endtask

    task automatic send_ar(input logic [7:0] addr, input logic [2:0] prot);
        arvalid = 1'b1;
        araddr  = addr;
        arprot  = prot;
        @(negedge clk);
        while (!arready) @(negedge clk);
        tick();
        arvalid = 1'b0;
    endtask

    task automatic wait_idle();
        while (exp_b_q.size() != 0 || exp_r_resp_q.size() != 0) tick();
    endtask

    // Order 0 sends AW first, 1 sends W first, 2 sends both together
    task automatic do_write(input logic [7:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
        int order;
        int gap;
        logic [2:0] prot;
        // Reads in flight must finish before the model changes
        while (exp_r_resp_q.size() != 0) tick();
        order = rnd_below(3);
        gap   = rnd_below(4);
        prot  = 3'(rnd_below(8));
        if (addr_ok(addr)) begin
            model_regs[addr / 4] = merge_bytes(model_regs[addr / 4], data, strb);
            exp_b_q.push_back(OKAY);
        end else begin
            exp_b_q.push_back(SLVERR);
        end
        fork
            send_aw(addr, prot, (order == 1) ? gap : 0);
            send_w(data, strb, (order == 0) ? gap : 0);
        join
    endtask

    task automatic do_read(input logic [7:0] addr);
        while (exp_b_q.size() != 0) tick();
        exp_r_resp_q.push_back(addr_ok(addr) ? OKAY : SLVERR);
        exp_r_data_q.push_back(addr_ok(addr) ? model_regs[addr / 4] : 32'h0);
        send_ar(addr, 3'(rnd_below(8)));
    endtask

    task automatic begin_phase(input string name);
        wait_idle();
        test_name = name;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Random back-pressure on both response channels
    initial begin
        ready_state = ~SEED;
        forever begin
            tick();
            ready_state = lcg_next(ready_state);
            bready = (ready_state[31:28] < 4'd11);
            ready_state = lcg_next(ready_state);
            rready = (ready_state[31:28] < 4'd11);
        end
    end

    always @(negedge clk) begin
        if (arst_n && bvalid && bready) begin
            if (exp_b_q.size() == 0) begin
                proto_errs++;
                $display("Write response arrived with no write outstanding in %s", test_name);
            end else begin
                check_resp({test_name, " bresp"}, exp_b_q.pop_front(), bresp);
            end
        end
    end

    always @(negedge clk) begin
        if (arst_n && rvalid && rready) begin
            if (exp_r_resp_q.size() == 0) begin
                proto_errs++;
                $display("Read response arrived with no read outstanding in %s", test_name);
            end else begin
                check_resp({test_name, " rresp"}, exp_r_resp_q.pop_front(), rresp);
                check_data({test_name, " rdata"}, exp_r_data_q.pop_front(), rdata);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, transactions were still pending", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int          kind;
        logic [7:0]  addr;
        logic [31:0] data;
        logic [3:0]  strb;
        int          total;
        arst_n    = 1'b0;
        awvalid   = 1'b0;
        awaddr    = '0;
        awprot    = '0;
        wvalid    = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        bready    = 1'b0;
        arvalid   = 1'b0;
        araddr    = '0;
        arprot    = '0;
        rready    = 1'b0;
        rng_state = SEED;
        resp_errs  = 0;
        data_errs  = 0;
        proto_errs = 0;
        test_name  = "reset";
        for (int i = 0; i < REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;

        begin_phase("reset_reads");
        for (int i = 0; i < REG_COUNT; i++) begin
            do_read(8'(i * 4));
        end

        begin_phase("write_readback");
        for (int i = 0; i < N_PAIR; i++) begin
            addr = make_addr(0);
            data = rnd_word();
            strb = 4'(rnd_below(16));
            do_write(addr, data, strb);
            do_read(addr);
        end

        begin_phase("bad_addr");
        for (int i = 0; i < N_BAD; i++) begin
            addr = make_addr(1 + rnd_below(2));
            data = rnd_word();
            if (i % 2 == 0) begin
                do_write(addr, data, 4'hf);
            end else begin
                do_read(addr);
            end
        end

        begin_phase("random_mix");
        for (int i = 0; i < N_MIX; i++) begin
            kind = rnd_below(10);
            addr = make_addr((kind < 8) ? 0 : kind - 7);
            data = rnd_word();
            strb = 4'(rnd_below(16));
            if (rnd_below(2) == 0) begin
                do_write(addr, data, strb);
            end else begin
                do_read(addr);
            end
        end

        // Catches any register touched by a rejected write
        begin_phase("final_sweep");
        for (int i = 0; i < REG_COUNT; i++) begin
            do_read(8'(i * 4));
        end
        wait_idle();
        repeat (20) tick();

        total = resp_errs + data_errs + proto_errs + u_dut.u_checker.assert_fails;
        $display("Errors: resp %0d, data %0d, protocol %0d, assertion %0d",
                 resp_errs, data_errs, proto_errs, u_dut.u_checker.assert_fails);
        if (total == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule : axi4l_reg_tb

`default_nettype wire

/* tests/axi4l_reg_checker.sv */
// Watches only the top-level AXI4-Lite ports; failures are also tallied in assert_fails
`default_nettype none

`include "axi4l_consts.svh"

module axi4l_reg_checker (
    input wire logic                                clk,
    input wire logic                                arst_n,
    input wire logic                                awvalid,
    input wire logic                                awready,
    input wire logic [`AXI4L_ADDR_WID-1:0]          awaddr,
    input wire logic [2:0]                          awprot,
    input wire logic                                wvalid,
    input wire logic                                wready,
    input wire logic [`AXI4L_DATA_BYTE_WID*8-1:0]   wdata,
    input wire logic [`AXI4L_DATA_BYTE_WID-1:0]     wstrb,
    input wire logic                                bvalid,
    input wire logic                                bready,
    input wire logic [1:0]                          bresp,
    input wire logic                                arvalid,
    input wire logic                                arready,
    input wire logic [`AXI4L_ADDR_WID-1:0]          araddr,
    input wire logic [2:0]                          arprot,
    input wire logic                                rvalid,
    input wire logic                                rready,
    input wire logic [`AXI4L_DATA_BYTE_WID*8-1:0]   rdata,
    input wire logic [1:0]                          rresp
);
    timeunit 1ns;
    timeprecision 100ps;

    int assert_fails = 0;

    // Requests hold valid and payload until accepted
    a_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
        ((awvalid && !awready) |=> (awvalid && $stable({awaddr, awprot}))) and
        ((wvalid && !wready) |=> (wvalid && $stable({wdata, wstrb}))) and
        ((arvalid && !arready) |=> (arvalid && $stable({araddr, arprot}))))
        else begin
            assert_fails++;
            $error("A request valid dropped or its payload changed before ready");
        end

    // Responses hold valid and payload until taken
    a_rsp_hold: assert property (@(posedge clk) disable iff (!arst_n)
        ((bvalid && !bready) |=> (bvalid && $stable(bresp))) and
        ((rvalid && !rready) |=> (rvalid && $stable({rdata, rresp}))))
        else begin
            assert_fails++;
            $error("A response valid dropped or its payload changed before ready");
        end

    a_reset_quiet: assert property (@(posedge clk)
        !arst_n |-> (!bvalid && !rvalid && !awready && !wready && !arready))
        else begin
            assert_fails++;
            $error("An output valid or ready was high during reset");
        end

endmodule : axi4l_reg_checker

`default_nettype wire

/* hdl/axi4l_reg_top.sv */
// Single clock domain; minimum request-to-response latency is three cycles per channel
`default_nettype none

`include "axi4l_consts.svh"

module axi4l_reg_top
    import axi4l_pkg::*;
(
    input  wire logic                                clk,
    input  wire logic                                arst_n,
    input  wire logic                                awvalid,
    output logic                                     awready,
    input  wire logic [`AXI4L_ADDR_WID-1:0]          awaddr,
    input  wire logic [2:0]                          awprot,
    input  wire logic                                wvalid,
    output logic                                     wready,
    input  wire logic [`AXI4L_DATA_BYTE_WID*8-1:0]   wdata,
    input  wire logic [`AXI4L_DATA_BYTE_WID-1:0]     wstrb,
    output logic                                     bvalid,
    input  wire logic                                bready,
    output resp_t                                    bresp,
    input  wire logic                                arvalid,
    output logic                                     arready,
    input  wire logic [`AXI4L_ADDR_WID-1:0]          araddr,
    input  wire logic [2:0]                          arprot,
    output logic                                     rvalid,
    input  wire logic                                rready,
    output logic [`AXI4L_DATA_BYTE_WID*8-1:0]        rdata,
    output resp_t                                    rresp
);
    axi4l_intf #(
        .ADDR_WID      (`AXI4L_ADDR_WID),
        .DATA_BYTE_WID (`AXI4L_DATA_BYTE_WID)
    ) axi_if (.clk(clk), .arst_n(arst_n));

    // Controller side of the interface comes from the ports
    assign axi_if.awvalid = awvalid;
    assign axi_if.awaddr  = awaddr;
    assign axi_if.awprot  = awprot;
    assign axi_if.wvalid  = wvalid;
    assign axi_if.wdata   = wdata;
    assign axi_if.wstrb   = wstrb;
    assign axi_if.bready  = bready;
    assign axi_if.arvalid = arvalid;
    assign axi_if.araddr  = araddr;
    assign axi_if.arprot  = arprot;
    assign axi_if.rready  = rready;

    assign awready = axi_if.awready;
    assign wready  = axi_if.wready;
    assign bvalid  = axi_if.bvalid;
    assign bresp   = resp_t'(axi_if.bresp);
    assign arready = axi_if.arready;
    assign rvalid  = axi_if.rvalid;
    assign rdata   = axi_if.rdata;
    assign rresp   = resp_t'(axi_if.rresp);

    // Adapter side and register block side of each slice
    bus_intf #(.DATA_WID($bits(ax_payload_t))) aw_adp_if (.clk(clk), .arst_n(arst_n));
    bus_intf #(.DATA_WID($bits(ax_payload_t))) aw_blk_if (.clk(clk), .arst_n(arst_n));
    bus_intf #(.DATA_WID($bits(w_payload_t)))  w_adp_if  (.clk(clk), .arst_n(arst_n));
    bus_intf #(.DATA_WID($bits(w_payload_t)))  w_blk_if  (.clk(clk), .arst_n(arst_n));
    bus_intf #(.DATA_WID($bits(ax_payload_t))) ar_adp_if (.clk(clk), .arst_n(arst_n));
    bus_intf #(.DATA_WID($bits(ax_payload_t))) ar_blk_if (.clk(clk), .arst_n(arst_n));
    bus_intf #(.DATA_WID($bits(b_payload_t)))  b_adp_if  (.clk(clk), .arst_n(arst_n));
    bus_intf #(.DATA_WID($bits(b_payload_t)))  b_blk_if  (.clk(clk), .arst_n(arst_n));
    bus_intf #(.DATA_WID($bits(r_payload_t)))  r_adp_if  (.clk(clk), .arst_n(arst_n));
    bus_intf #(.DATA_WID($bits(r_payload_t)))  r_blk_if  (.clk(clk), .arst_n(arst_n));

    axi4l_to_bus_adapter u_adapter (
        .axi4l_if  (axi_if),
        .aw_bus_if (aw_adp_if),
        .w_bus_if  (w_adp_if),
        .ar_bus_if (ar_adp_if),
        .b_bus_if  (b_adp_if),
        .r_bus_if  (r_adp_if)
    );

    // Requests flow toward the block, responses flow back
    bus_pipe #(.DATA_WID($bits(ax_payload_t))) u_aw_pipe (.in_if(aw_adp_if), .out_if(aw_blk_if));
    bus_pipe #(.DATA_WID($bits(w_payload_t)))  u_w_pipe  (.in_if(w_adp_if),  .out_if(w_blk_if));
    bus_pipe #(.DATA_WID($bits(ax_payload_t))) u_ar_pipe (.in_if(ar_adp_if), .out_if(ar_blk_if));
    bus_pipe #(.DATA_WID($bits(b_payload_t)))  u_b_pipe  (.in_if(b_blk_if),  .out_if(b_adp_if));
    bus_pipe #(.DATA_WID($bits(r_payload_t)))  u_r_pipe  (.in_if(r_blk_if),  .out_if(r_adp_if));

    bus_reg_block u_reg_block (
        .aw_if (aw_blk_if),
        .w_if  (w_blk_if),
        .ar_if (ar_blk_if),
        .b_if  (b_blk_if),
        .r_if  (r_blk_if)
    );

endmodule : axi4l_reg_top

`default_nettype wire

/* hdl/bus_reg_block.sv */
// Registers reset to zero; protection bits are accepted and ignored
`default_nettype none

`include "axi4l_consts.svh"

module bus_reg_block
    import axi4l_pkg::*;
(
    bus_intf.rx aw_if,
    bus_intf.rx w_if,
    bus_intf.rx ar_if,
    bus_intf.tx b_if,
    bus_intf.tx r_if
);
    localparam int REG_COUNT  = `AXI4L_REG_COUNT;
    localparam int BYTE_WID   = `AXI4L_DATA_BYTE_WID;
    localparam int DATA_WID   = BYTE_WID * 8;
    localparam int OFS_WID    = $clog2(BYTE_WID);
    localparam int IDX_WID    = $clog2(REG_COUNT);
    localparam int ADDR_LIMIT = REG_COUNT * BYTE_WID;

    ax_payload_t         aw_pl;
    w_payload_t          w_pl;
    ax_payload_t         ar_pl;
    b_payload_t          b_pl;
    r_payload_t          r_pl;

    logic [DATA_WID-1:0] regs [REG_COUNT];

    // Write side
    wr_state_t           wr_state;
    resp_t               b_resp;
    logic                wr_fire;
    logic                wr_ok;
    logic [IDX_WID-1:0]  wr_idx;

    // Read side
    logic                r_valid;
    logic [DATA_WID-1:0] r_data;
    resp_t               r_resp;
    logic                rd_fire;
    logic                rd_ok;
    logic [IDX_WID-1:0]  rd_idx;

    // Word-aligned and inside the register window
    function automatic logic addr_ok(input logic [`AXI4L_ADDR_WID-1:0] addr);
        return (addr[OFS_WID-1:0] == '0) && (addr < ADDR_LIMIT);
    endfunction

    assign aw_pl = aw_if.data;
    assign w_pl  = w_if.data;
    assign ar_pl = ar_if.data;

    // AW and W are taken together, one write in flight at a time
    assign wr_fire     = aw_if.valid && w_if.valid && (wr_state == WR_IDLE);
    assign aw_if.ready = wr_fire;
    assign w_if.ready  = wr_fire;
    assign wr_ok       = addr_ok(aw_pl.addr);
    assign wr_idx      = aw_pl.addr[OFS_WID +: IDX_WID];

    always_ff @(posedge aw_if.clk or negedge aw_if.arst_n) begin
        if (!aw_if.arst_n) begin
            wr_state <= WR_IDLE;
        end else begin
            case (wr_state)
                WR_IDLE: begin
                    if (wr_fire) begin
                        wr_state <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    if (b_if.ready) begin
                        wr_state <= WR_IDLE;
                    end
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge aw_if.clk or negedge aw_if.arst_n) begin
        if (!aw_if.arst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_fire && wr_ok) begin
            // Merge only the strobed bytes
            for (int b = 0; b < BYTE_WID; b++) begin
                if (w_pl.strb[b]) begin
                    regs[wr_idx][8*b +: 8] <= w_pl.data[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge aw_if.clk) begin
        if (wr_fire) begin
            b_resp <= wr_ok ? OKAY : SLVERR;
        end
    end

    assign b_pl.resp  = b_resp;
    assign b_if.valid = (wr_state == WR_RESP);
    assign b_if.data  = b_pl;

    // Single R slot, refilled in the cycle it is taken
    assign ar_if.ready = !r_valid || r_if.ready;
    assign rd_fire     = ar_if.valid && ar_if.ready;
    assign rd_ok       = addr_ok(ar_pl.addr);
    assign rd_idx      = ar_pl.addr[OFS_WID +: IDX_WID];

    always_ff @(posedge ar_if.clk or negedge ar_if.arst_n) begin
        if (!ar_if.arst_n) begin
            r_valid <= 1'b0;
        end else if (rd_fire) begin
            r_valid <= 1'b1;
        end else if (r_if.ready) begin
            r_valid <= 1'b0;
        end
    end

    always_ff @(posedge ar_if.clk) begin
        if (rd_fire) begin
            r_data <= rd_ok ? regs[rd_idx] : '0;
            r_resp <= rd_ok ? OKAY : SLVERR;
        end
    end

    assign r_pl.data  = r_data;
    assign r_pl.resp  = r_resp;
    assign r_if.valid = r_valid;
    assign r_if.data  = r_pl;

endmodule : bus_reg_block

`default_nettype wire

/* hdl/bus_pipe.sv */
// Adds one cycle of latency at full throughput; input ready is low during reset
`default_nettype none

module bus_pipe #(
    parameter int DATA_WID = 8
) (
    bus_intf.rx in_if,
    bus_intf.tx out_if
);
    // Main entry drives the output, skid entry catches the item in flight
    logic                main_valid;
    logic [DATA_WID-1:0] main_data;
    logic                skid_valid;
    logic [DATA_WID-1:0] skid_data;
    logic                in_ready;

    logic                in_fire;
    logic                main_free;
    logic                main_valid_nxt;
    logic                skid_valid_nxt;

    assign in_fire = in_if.valid && in_ready;

    // Main is free when empty or being emptied this cycle
    assign main_free = !main_valid || out_if.ready;

    always_comb begin
        main_valid_nxt = main_valid;
        skid_valid_nxt = skid_valid;
        if (main_free) begin
            // Skid drains first, so order is kept
            main_valid_nxt = skid_valid || in_fire;
            skid_valid_nxt = 1'b0;
        end else if (in_fire) begin
            skid_valid_nxt = 1'b1;
        end
    end

    always_ff @(posedge in_if.clk or negedge in_if.arst_n) begin
        if (!in_if.arst_n) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
            in_ready   <= 1'b0;
        end else begin
            main_valid <= main_valid_nxt;
            skid_valid <= skid_valid_nxt;
            // Registered, never a function of out_if.ready in the same cycle
            in_ready   <= !skid_valid_nxt;
        end
    end

    always_ff @(posedge in_if.clk) begin
        if (main_free) begin
            main_data <= skid_valid ? skid_data : in_if.data;
        end else if (in_fire) begin
            skid_data <= in_if.data;
        end
    end

    assign in_if.ready  = in_ready;
    assign out_if.valid = main_valid;
    assign out_if.data  = main_data;

endmodule : bus_pipe

`default_nettype wire

/* hdl/axi4l_to_bus_adapter.sv */
// Purely combinational; bus widths must equal the payload struct widths from axi4l_pkg
`default_nettype none

module axi4l_to_bus_adapter
    import axi4l_pkg::*;
(
    // AXI4-Lite side, from the controller
    axi4l_intf.peripheral axi4l_if,

    // Request buses toward the register block
    bus_intf.tx           aw_bus_if,
    bus_intf.tx           w_bus_if,
    bus_intf.tx           ar_bus_if,

    // Response buses back from the register block
    bus_intf.rx           b_bus_if,
    bus_intf.rx           r_bus_if
);
    ax_payload_t aw_payload;
    w_payload_t  w_payload;
    ax_payload_t ar_payload;
    b_payload_t  b_payload;
    r_payload_t  r_payload;

    // Pack the request channels
    assign aw_payload.addr = axi4l_if.awaddr;
    assign aw_payload.prot = axi4l_if.awprot;

    assign w_payload.data  = axi4l_if.wdata;
    assign w_payload.strb  = axi4l_if.wstrb;

    assign ar_payload.addr = axi4l_if.araddr;
    assign ar_payload.prot = axi4l_if.arprot;

    // Write address
    assign aw_bus_if.valid = axi4l_if.awvalid;
    assign aw_bus_if.data  = aw_payload;
    assign axi4l_if.awready = aw_bus_if.ready;

    // Write data
    assign w_bus_if.valid = axi4l_if.wvalid;
    assign w_bus_if.data  = w_payload;
    assign axi4l_if.wready = w_bus_if.ready;

    // Read address
    assign ar_bus_if.valid = axi4l_if.arvalid;
    assign ar_bus_if.data  = ar_payload;
    assign axi4l_if.arready = ar_bus_if.ready;

    // Unpack the response buses
    assign b_payload = b_bus_if.data;
    assign r_payload = r_bus_if.data;

    // Write response
    assign axi4l_if.bvalid = b_bus_if.valid;
    assign axi4l_if.bresp  = b_payload.resp;
    assign b_bus_if.ready  = axi4l_if.bready;

    // Read data
    assign axi4l_if.rvalid = r_bus_if.valid;
    assign axi4l_if.rdata  = r_payload.data;
    assign axi4l_if.rresp  = r_payload.resp;
    assign r_bus_if.ready  = axi4l_if.rready;

endmodule : axi4l_to_bus_adapter

`default_nettype wire

/* hdl/bus_intf.sv */
// Payload is opaque here; both ends must agree on DATA_WID and its packing
`default_nettype none

interface bus_intf #(
    parameter int DATA_WID = 8
) (
    input wire logic clk,
    input wire logic arst_n
);
    logic                valid;
    logic                ready;
    logic [DATA_WID-1:0] data;

    // Sender holds valid and data until the cycle where ready is also high
    modport tx (
        input  clk,
        input  arst_n,
        output valid,
        output data,
        input  ready
    );

    modport rx (
        input  clk,
        input  arst_n,
        input  valid,
        input  data,
        output ready
    );

endinterface : bus_intf

`default_nettype wire

/* hdl/axi4l_intf.sv */
// AXI4-Lite with no ID, user or exclusive signals; responses are raw 2-bit codes
`default_nettype none

`include "axi4l_consts.svh"

interface axi4l_intf #(
    parameter int ADDR_WID      = `AXI4L_ADDR_WID,
    parameter int DATA_BYTE_WID = `AXI4L_DATA_BYTE_WID
) (
    input wire logic clk,
    input wire logic arst_n
);
    localparam int DATA_WID = DATA_BYTE_WID * 8;

    // Write address
    logic                     awvalid;
    logic                     awready;
    logic [ADDR_WID-1:0]      awaddr;
    logic [2:0]               awprot;

    // Write data
    logic                     wvalid;
    logic                     wready;
    logic [DATA_WID-1:0]      wdata;
    logic [DATA_BYTE_WID-1:0] wstrb;

    // Write response
    logic                     bvalid;
    logic                     bready;
    logic [1:0]               bresp;

    // Read address
    logic                     arvalid;
    logic                     arready;
    logic [ADDR_WID-1:0]      araddr;
    logic [2:0]               arprot;

    // Read data
    logic                     rvalid;
    logic                     rready;
    logic [DATA_WID-1:0]      rdata;
    logic [1:0]               rresp;

    modport controller (
        input  clk, arst_n,
        output awvalid, awaddr, awprot, input  awready,
        output wvalid, wdata, wstrb,    input  wready,
        input  bvalid, bresp,           output bready,
        output arvalid, araddr, arprot, input  arready,
        input  rvalid, rdata, rresp,    output rready
    );

    modport peripheral (
        input  clk, arst_n,
        input  awvalid, awaddr, awprot, output awready,
        input  wvalid, wdata, wstrb,    output wready,
        output bvalid, bresp,           input  bready,
        input  arvalid, araddr, arprot, output arready,
        output rvalid, rdata, rresp,    input  rready
    );

endinterface : axi4l_intf

`default_nettype wire

/* hdl/axi4l_pkg.sv */
// Payload layouts follow the consts header; EXOKAY and DECERR exist only as encodings
`default_nettype none

`include "axi4l_consts.svh"

package axi4l_pkg;

    // AXI response codes
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_t;

    // Write response state of the register block
    typedef enum logic {
        WR_IDLE = 1'b0,
        WR_RESP = 1'b1
    } wr_state_t;

    // Shared by AW and AR
    typedef struct packed {
        logic [2:0]                  prot;
        logic [`AXI4L_ADDR_WID-1:0]  addr;
    } ax_payload_t;

    typedef struct packed {
        logic [`AXI4L_DATA_BYTE_WID*8-1:0] data;
        logic [`AXI4L_DATA_BYTE_WID-1:0]   strb;
    } w_payload_t;

    typedef struct packed {
        resp_t resp;
    } b_payload_t;

    typedef struct packed {
        logic [`AXI4L_DATA_BYTE_WID*8-1:0] data;
        resp_t                             resp;
    } r_payload_t;

endpackage : axi4l_pkg

`default_nettype wire

/* hdl/axi4l_consts.svh */
// Sizes are fixed at compile time and REG_COUNT * DATA_BYTE_WID must stay below 2**ADDR_WID
`ifndef AXI4L_CONSTS_SVH
`define AXI4L_CONSTS_SVH

// Byte address width on AW and AR
`define AXI4L_ADDR_WID 8

// Data path width in bytes, one strobe bit per byte
`define AXI4L_DATA_BYTE_WID 4

// Registers in the block, each one data word wide
`define AXI4L_REG_COUNT 16

`endif
